// File: source/mem_macros.svh
/*
 * Memory geometry shared by the packages and the RTL.
 * The depth always equals 2**MEM_ADDR_W, so addresses wrap modulo the depth.
 * MEM_DATA_W must stay 32 to match the AXI4-Lite data bus.
 */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Byte address width
`define MEM_ADDR_W 10

// Word width of the RAM port
`define MEM_DATA_W 32

// Number of bytes in the array
`define MEM_DEPTH (1 << `MEM_ADDR_W)

`endif

// File: source/axil_pkg.sv
/*
 * AXI4-Lite channel payloads, 32-bit address and data.
 * Only OKAY and SLVERR responses are produced by this slave.
 */
package axil_pkg;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // Address channels, master side
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  prot;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    typedef struct packed {
        logic [31:0] data;
        axil_resp_e  resp;
    } axil_r_t;

endpackage

// File: source/mem_pkg.sv
/*
 * RAM request format and controller state encodings.
 * Access size codes follow the load/store unit encoding.
 */
`include "mem_macros.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        SIZE_NONE = 2'd0,
        SIZE_BYTE = 2'd1,
        SIZE_HALF = 2'd2,
        SIZE_WORD = 2'd3
    } access_size_e;

    // One request on the single RAM port, data in the low lanes
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`MEM_DATA_W-1:0] data;
        access_size_e           size;
        logic                   wen;
        logic                   ren;
    } mem_req_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ISSUE,
        WR_RESP
    } wr_state_e;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ISSUE,
        RD_WAIT,
        RD_RESP
    } rd_state_e;

endpackage

// File: source/byte_ram.sv
/*
 * Byte-wide RAM with byte, half and word stores from the low data lanes.
 * Word read is registered, lowest address in the low byte.
 * Multi-byte accesses wrap at the top of the array.
 * Synchronous reset clears o_dout and every byte.
 */
`timescale 1ns/100ps
`include "mem_macros.svh"

module byte_ram import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   i_rst,
    input  mem_req_t               i_req,
    output logic [`MEM_DATA_W-1:0] o_dout
);

    logic [7:0] mem [`MEM_DEPTH];

    logic [`MEM_ADDR_W-1:0] addr1;
    logic [`MEM_ADDR_W-1:0] addr2;
    logic [`MEM_ADDR_W-1:0] addr3;

    // Neighbour addresses, wrap modulo the depth
    assign addr1 = i_req.addr + `MEM_ADDR_W'(1);
    assign addr2 = i_req.addr + `MEM_ADDR_W'(2);
    assign addr3 = i_req.addr + `MEM_ADDR_W'(3);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_dout <= '0;
            for (int i = 0; i < `MEM_DEPTH; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (i_req.wen && !i_req.ren) begin
            case (i_req.size)
                SIZE_BYTE: begin
                    mem[i_req.addr] <= i_req.data[7:0];
                end
                SIZE_HALF: begin
                    mem[i_req.addr] <= i_req.data[7:0];
                    mem[addr1]      <= i_req.data[15:8];
                end
                SIZE_WORD: begin
                    mem[i_req.addr] <= i_req.data[7:0];
                    mem[addr1]      <= i_req.data[15:8];
                    mem[addr2]      <= i_req.data[23:16];
                    mem[addr3]      <= i_req.data[31:24];
                end
                default: begin
                end
            endcase
        end else if (i_req.ren && !i_req.wen) begin
            o_dout <= {mem[addr3], mem[addr2], mem[addr1], mem[i_req.addr]};
        end
    end

endmodule

// File: source/axil_write_ctrl.sv
/*
 * AXI4-Lite write channel. AW and W are taken in one common cycle.
 * Legal strobes: one lane, lower or upper half, or all four lanes.
 * Any other strobe, zero included, gets SLVERR and writes nothing.
 * PROT is ignored and the address wraps modulo the RAM depth.
 */
`timescale 1ns/100ps
`include "mem_macros.svh"

module axil_write_ctrl import axil_pkg::*, mem_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_aw_valid,
    input  axil_aw_t i_aw,
    output logic     o_aw_ready,
    input  logic     i_w_valid,
    input  axil_w_t  i_w,
    output logic     o_w_ready,
    output logic     o_b_valid,
    output axil_b_t  o_b,
    input  logic     i_b_ready,
    output logic     o_req_valid,
    output mem_req_t o_req,
    input  logic     i_grant
);

    wr_state_e    state;
    mem_req_t     req_q;
    axil_resp_e   resp_q;
    access_size_e dec_size;
    logic [1:0]   dec_off;
    logic         accept;

    // Strobe to size and byte offset
    always_comb begin
        dec_size = SIZE_NONE;
        dec_off  = 2'd0;
        case (i_w.strb)
            4'b0001: dec_size = SIZE_BYTE;
            4'b0010: begin
                dec_size = SIZE_BYTE;
                dec_off  = 2'd1;
            end
            4'b0100: begin
                dec_size = SIZE_BYTE;
                dec_off  = 2'd2;
            end
            4'b1000: begin
                dec_size = SIZE_BYTE;
                dec_off  = 2'd3;
            end
            4'b0011: dec_size = SIZE_HALF;
            4'b1100: begin
                dec_size = SIZE_HALF;
                dec_off  = 2'd2;
            end
            4'b1111: dec_size = SIZE_WORD;
            default: dec_size = SIZE_NONE;
        endcase
    end

    // Both channels must be valid before either is accepted
    assign accept      = (state == WR_IDLE) && i_aw_valid && i_w_valid;
    assign o_aw_ready  = accept;
    assign o_w_ready   = accept;
    assign o_req_valid = (state == WR_ISSUE);
    assign o_req       = req_q;
    assign o_b_valid   = (state == WR_RESP);
    assign o_b.resp    = resp_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (accept) begin
                        // Illegal strobe goes straight to the response
                        state <= (dec_size == SIZE_NONE) ? WR_RESP : WR_ISSUE;
                    end
                end
                WR_ISSUE: if (i_grant) state <= WR_RESP;
                WR_RESP:  if (i_b_ready) state <= WR_IDLE;
                default:  state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q.addr <= {i_aw.addr[`MEM_ADDR_W-1:2], dec_off};
            // Selected lanes moved down to the low end
            req_q.data <= i_w.data >> {dec_off, 3'b000};
            req_q.size <= dec_size;
            req_q.wen  <= 1'b1;
            req_q.ren  <= 1'b0;
            resp_q     <= (dec_size == SIZE_NONE) ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

// File: source/axil_read_ctrl.sv
/*
 * AXI4-Lite read channel. Always returns the aligned word with OKAY.
 * RAM data is captured one cycle after the grant and held until RREADY.
 * PROT is ignored and the address wraps modulo the RAM depth.
 */
`timescale 1ns/100ps
`include "mem_macros.svh"

module axil_read_ctrl import axil_pkg::*, mem_pkg::*; (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_ar_valid,
    input  axil_ar_t               i_ar,
    output logic                   o_ar_ready,
    output logic                   o_r_valid,
    output axil_r_t                o_r,
    input  logic                   i_r_ready,
    output logic                   o_req_valid,
    output mem_req_t               o_req,
    input  logic                   i_grant,
    input  logic [`MEM_DATA_W-1:0] i_rdata
);

    rd_state_e              state;
    logic [`MEM_ADDR_W-1:0] addr_q;
    logic [`MEM_DATA_W-1:0] rdata_q;

    assign o_ar_ready  = (state == RD_IDLE);
    assign o_req_valid = (state == RD_ISSUE);
    assign o_r_valid   = (state == RD_RESP);
    assign o_r.data    = rdata_q;
    assign o_r.resp    = RESP_OKAY;

    assign o_req.addr = addr_q;
    assign o_req.data = '0;
    assign o_req.size = SIZE_WORD;
    assign o_req.wen  = 1'b0;
    assign o_req.ren  = 1'b1;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE:  if (i_ar_valid) state <= RD_ISSUE;
                RD_ISSUE: if (i_grant) state <= RD_WAIT;
                RD_WAIT:  state <= RD_RESP;
                RD_RESP:  if (i_r_ready) state <= RD_IDLE;
                default:  state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_ar_ready && i_ar_valid) begin
            addr_q <= {i_ar.addr[`MEM_ADDR_W-1:2], 2'b00};
        end
        // o_dout is valid for this one cycle only
        if (state == RD_WAIT) begin
            rdata_q <= i_rdata;
        end
    end

endmodule

// File: source/mem_port_arbiter.sv
/*
 * Round-robin arbiter for the single RAM port. Grants are combinational.
 * On a tie the requester not served last wins; a read wins the first tie.
 */
`timescale 1ns/100ps

module mem_port_arbiter import mem_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_wr_valid,
    input  mem_req_t i_wr_req,
    input  logic     i_rd_valid,
    input  mem_req_t i_rd_req,
    output logic     o_wr_grant,
    output logic     o_rd_grant,
    output mem_req_t o_req
);

    // High when the write side was served last
    logic last_wr;

    assign o_wr_grant = i_wr_valid && (!i_rd_valid || !last_wr);
    assign o_rd_grant = i_rd_valid && (!i_wr_valid || last_wr);

    always_comb begin
        o_req = '{addr: '0, data: '0, size: SIZE_NONE, wen: 1'b0, ren: 1'b0};
        if (o_wr_grant) begin
            o_req = i_wr_req;
        end else if (o_rd_grant) begin
            o_req = i_rd_req;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            last_wr <= 1'b1;
        end else if (o_wr_grant) begin
            last_wr <= 1'b1;
        end else if (o_rd_grant) begin
            last_wr <= 1'b0;
        end
    end

endmodule

// File: source/axil_mem_top.sv
/*
 * AXI4-Lite slave data memory. Read and write channels run independently
 * and share one RAM port. No bursts, no PROT checks, no decode errors.
 */
`timescale 1ns/100ps
`include "mem_macros.svh"

module axil_mem_top import axil_pkg::*, mem_pkg::*; (
    input  logic     clk,
    input  logic     i_rst,
    input  logic     i_aw_valid,
    input  axil_aw_t i_aw,
    output logic     o_aw_ready,
    input  logic     i_w_valid,
    input  axil_w_t  i_w,
    output logic     o_w_ready,
    output logic     o_b_valid,
    output axil_b_t  o_b,
    input  logic     i_b_ready,
    input  logic     i_ar_valid,
    input  axil_ar_t i_ar,
    output logic     o_ar_ready,
    output logic     o_r_valid,
    output axil_r_t  o_r,
    input  logic     i_r_ready
);

    logic                   wr_req_valid;
    mem_req_t               wr_req;
    logic                   wr_grant;
    logic                   rd_req_valid;
    mem_req_t               rd_req;
    logic                   rd_grant;
    mem_req_t               ram_req;
    logic [`MEM_DATA_W-1:0] ram_dout;

    axil_write_ctrl u_write_ctrl (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_aw_valid  (i_aw_valid),
        .i_aw        (i_aw),
        .o_aw_ready  (o_aw_ready),
        .i_w_valid   (i_w_valid),
        .i_w         (i_w),
        .o_w_ready   (o_w_ready),
        .o_b_valid   (o_b_valid),
        .o_b         (o_b),
        .i_b_ready   (i_b_ready),
        .o_req_valid (wr_req_valid),
        .o_req       (wr_req),
        .i_grant     (wr_grant)
    );

    axil_read_ctrl u_read_ctrl (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_ar_valid  (i_ar_valid),
        .i_ar        (i_ar),
        .o_ar_ready  (o_ar_ready),
        .o_r_valid   (o_r_valid),
        .o_r         (o_r),
        .i_r_ready   (i_r_ready),
        .o_req_valid (rd_req_valid),
        .o_req       (rd_req),
        .i_grant     (rd_grant),
        .i_rdata     (ram_dout)
    );

    mem_port_arbiter u_arbiter (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_wr_valid (wr_req_valid),
        .i_wr_req   (wr_req),
        .i_rd_valid (rd_req_valid),
        .i_rd_req   (rd_req),
        .o_wr_grant (wr_grant),
        .o_rd_grant (rd_grant),
        .o_req      (ram_req)
    );

    byte_ram u_ram (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_req  (ram_req),
        .o_dout (ram_dout)
    );

endmodule

// File: tests/tb_axil_mem.sv
/*
 * Testbench for axil_mem_top, with AXI4-Lite master tasks and a byte-array model.
 * Concurrent read/write pairs always target different words, so the expected
 * read data does not depend on arbitration order.
 */
`timescale 1ns/100ps
`include "mem_macros.svh"

module tb_axil_mem import axil_pkg::*; ();

    localparam int WORDS = `MEM_DEPTH / 4;
    // About 250 transactions of at most ~15 cycles each, with a wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic     clk = 1'b0;
    logic     i_rst;
    logic     aw_valid;
    axil_aw_t aw;
    logic     aw_ready;
    logic     w_valid;
    axil_w_t  w;
    logic     w_ready;
    logic     b_valid;
    axil_b_t  b;
    logic     b_ready;
    logic     ar_valid;
    axil_ar_t ar;
    logic     ar_ready;
    logic     r_valid;
    axil_r_t  r;
    logic     r_ready;

    logic [7:0] model [`MEM_DEPTH];
    int         cycles = 0;
    logic [3:0] legal_strb [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                   4'b0011, 4'b1100, 4'b1111};

    axil_mem_top UUT (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_aw_valid (aw_valid),
        .i_aw       (aw),
        .o_aw_ready (aw_ready),
        .i_w_valid  (w_valid),
        .i_w        (w),
        .o_w_ready  (w_ready),
        .o_b_valid  (b_valid),
        .o_b        (b),
        .i_b_ready  (b_ready),
        .i_ar_valid (ar_valid),
        .i_ar       (ar),
        .o_ar_ready (ar_ready),
        .o_r_valid  (r_valid),
        .o_r        (r),
        .i_r_ready  (r_ready)
    );

    always #10 clk = ~clk;

    task automatic end_with_failure();
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic protocol_error(input string what);
        $display("Protocol error at %0t: %s", $time, what);
        end_with_failure();
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_with_failure();
        end
    end

    // Responses must stay valid with a stable payload until the handshake
    b_hold: assert property (@(posedge clk) disable iff (i_rst)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else protocol_error("B response dropped or changed before BREADY");
    r_hold: assert property (@(posedge clk) disable iff (i_rst)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else protocol_error("R response dropped or changed before RREADY");

    function automatic logic strobe_legal(input logic [3:0] strb);
        case (strb)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: return 1'b1;
            4'b0011, 4'b1100, 4'b1111: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Each strobed lane lands at the aligned address plus its lane number
    function automatic void model_write(input logic [31:0] addr, input logic [31:0] data,
                                        input logic [3:0] strb);
        logic [`MEM_ADDR_W-1:0] base;
        base = {addr[`MEM_ADDR_W-1:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                model[base + `MEM_ADDR_W'(k)] = data[8*k +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [`MEM_ADDR_W-1:0] base;
        base = {addr[`MEM_ADDR_W-1:2], 2'b00};
        return {model[base + `MEM_ADDR_W'(3)], model[base + `MEM_ADDR_W'(2)],
                model[base + `MEM_ADDR_W'(1)], model[base]};
    endfunction

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output axil_resp_e resp);
        logic done;
        @(posedge clk);
        aw_valid <= 1'b1;
        aw       <= '{addr: addr, prot: 3'b000};
        w_valid  <= 1'b1;
        w        <= '{data: data, strb: strb};
        @(posedge clk);
        while (!(aw_ready && w_ready)) @(posedge clk);
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        b_ready  <= ($urandom_range(3) != 0);
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (b_valid && b_ready) begin
                done = 1'b1;
                resp = b.resp;
            end else begin
                b_ready <= ($urandom_range(3) != 0);
            end
        end
        b_ready <= 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output axil_resp_e resp);
        logic done;
        @(posedge clk);
        ar_valid <= 1'b1;
        ar       <= '{addr: addr, prot: 3'b000};
        @(posedge clk);
        while (!ar_ready) @(posedge clk);
        ar_valid <= 1'b0;
        r_ready  <= ($urandom_range(3) != 0);
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            if (r_valid && r_ready) begin
                done = 1'b1;
                data = r.data;
                resp = r.resp;
            end else begin
                r_ready <= ($urandom_range(3) != 0);
            end
        end
        r_ready <= 1'b0;
    endtask

    task automatic check_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        axil_resp_e exp_resp;
        axil_resp_e got_resp;
        exp_resp = strobe_legal(strb) ? RESP_OKAY : RESP_SLVERR;
        axi_write(addr, data, strb, got_resp);
        assert (got_resp == exp_resp) else begin
            $display("MISMATCH at %0t: write 0x%08h strobe %b gave %s, expected %s",
                     $time, addr, strb, got_resp.name(), exp_resp.name());
            end_with_failure();
        end
        if (strobe_legal(strb)) begin
            model_write(addr, data, strb);
        end
    endtask

    task automatic check_read(input logic [31:0] addr);
        logic [31:0] exp_data;
        logic [31:0] got_data;
        axil_resp_e  got_resp;
        exp_data = model_word(addr);
        axi_read(addr, got_data, got_resp);
        assert (got_data == exp_data && got_resp == RESP_OKAY) else begin
            $display("MISMATCH at %0t: read 0x%08h gave 0x%08h %s, expected 0x%08h OKAY",
                     $time, addr, got_data, got_resp.name(), exp_data);
            end_with_failure();
        end
    endtask

    initial begin
        logic [31:0] wr_addr;
        logic [31:0] wr_data;
        logic [31:0] rd_addr;
        logic [3:0]  wr_strb;
        int          wr_word;
        void'($urandom(20904));
        i_rst    = 1'b1;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar       = '0;
        r_ready  = 1'b0;
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            model[i] = 8'h00;
        end
        repeat (5) @(posedge clk);
        i_rst <= 1'b0;

        // Cleared memory, including an address above the depth
        check_read(32'h0000_0000);
        check_read(32'h0000_0123);
        check_read(32'h0000_03fc);
        check_read(32'h0000_1404);

        for (int i = 0; i < 8; i++) begin
            check_write(32'(i * 36), 32'ha5c3_e100 + 32'(i), 4'b1111);
        end
        for (int i = 0; i < 8; i++) begin
            check_read(32'(i * 36));
        end

        // Byte and half stores merge into the words above
        for (int i = 0; i < 6; i++) begin
            check_write(32'(i * 36), 32'h1234_5678 * 32'(i + 3), legal_strb[i]);
            check_read(32'(i * 36));
        end

        // Every illegal strobe pattern leaves the word alone
        for (int s = 0; s < 16; s++) begin
            if (!strobe_legal(4'(s))) begin
                check_write(32'd72, 32'hdead_beef, 4'(s));
                check_read(32'd72);
            end
        end

        // One write and one read in flight together, always on different words
        for (int n = 0; n < 100; n++) begin
            wr_word = int'($urandom_range(WORDS - 1));
            wr_addr = $urandom();
            wr_addr[`MEM_ADDR_W-1:2] = (`MEM_ADDR_W-2)'(wr_word);
            rd_addr = $urandom();
            rd_addr[`MEM_ADDR_W-1:2] =
                (`MEM_ADDR_W-2)'((wr_word + 1 + int'($urandom_range(WORDS - 2))) % WORDS);
            wr_data = $urandom();
            wr_strb = ($urandom_range(7) == 0) ? 4'($urandom_range(15))
                                               : legal_strb[$urandom_range(6)];
            fork
                begin
                    repeat ($urandom_range(2)) @(posedge clk);
                    check_write(wr_addr, wr_data, wr_strb);
                end
                begin
                    repeat ($urandom_range(2)) @(posedge clk);
                    check_read(rd_addr);
                end
            join
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+source
source/axil_pkg.sv
source/mem_pkg.sv
source/byte_ram.sv
source/axil_write_ctrl.sv
source/axil_read_ctrl.sv
source/mem_port_arbiter.sv
source/axil_mem_top.sv
tests/tb_axil_mem.sv

// File: Makefile
# Verilator build of the AXI4-Lite memory testbench.
# The run target fails whenever the simulation ends in $fatal.

VERILATOR ?= verilator
TOP       ?= tb_axil_mem
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh tests/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
